/* common/sldu_macros.svh */
// ------------------------------------------------
// Slide unit sizing macros
// Lane count, queue depths, register size, ids
// ------------------------------------------------

`ifndef SLDU_MACROS_SVH
`define SLDU_MACROS_SVH

// Lanes, each with a 64-bit datapath
`define SLDU_NR_LANES 4
// Bytes in one register-file word, eight per lane
`define SLDU_WORD_BYTES (8 * `SLDU_NR_LANES)
// Queue depths
`define SLDU_INSN_DEPTH 2
`define SLDU_RESULT_DEPTH 2
// Instruction ids and words per vector register
`define SLDU_NR_VINSN 8
`define SLDU_REG_WORDS 8

`endif

/* common/sldu_pkg.sv */
// ------------------------------------------------
// Slide unit package
// Vector types, operation and element-width enums
// and the request passed down from the sequencer
// ------------------------------------------------

`include "sldu_macros.svh"

package sldu_pkg;

  // One lane's data word and its byte enables
  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;

  // Lengths and counts, in elements or bytes
  typedef logic [15:0] vlen_t;
  // Register-file word address
  typedef logic [7:0]  vaddr_t;
  typedef logic [$clog2(`SLDU_NR_VINSN)-1:0] vid_t;
  typedef logic [4:0]  vreg_t;

  // Value is log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  typedef enum logic {
    SLIDE_UP,
    SLIDE_DOWN
  } slide_op_e;

  // Stride is in elements as issued, bytes once queued
  typedef struct packed {
    vid_t      id;
    slide_op_e op;
    vsew_e     vsew;
    vreg_t     vd;
    vlen_t     vl;
    vlen_t     stride;
  } slide_req_t;

  // One done bit per instruction id
  typedef logic [`SLDU_NR_VINSN-1:0] done_vec_t;

endpackage

/* common/result_word_if.sv */
// ------------------------------------------------
// Result word channel
// One destination word from slide engine to queue
// ------------------------------------------------

`include "sldu_macros.svh"

interface result_word_if import sldu_pkg::*; ();

  // Word is written in any cycle with push high
  logic push;
  // Queue has no free entry
  logic full;

  // Per-lane payload, shared address and id
  elen_t  [`SLDU_NR_LANES-1:0] data;
  strb_t  [`SLDU_NR_LANES-1:0] be;
  vaddr_t                      addr;
  vid_t                        id;

  // Engine side
  modport master (output push, data, be, addr, id, input full);
  // Queue side
  modport slave (input push, data, be, addr, id, output full);

endinterface

/* hdl/insn_queue.sv */
// ------------------------------------------------
// Slide instruction queue
// Holds in-flight requests with separate accept,
// issue and commit pointers
// ------------------------------------------------

`include "sldu_macros.svh"

module insn_queue import sldu_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  slide_req_t req_i,
  input  logic       req_valid_i,
  output logic       req_ready_o,
  output slide_req_t issue_req_o,
  output logic       issue_valid_o,
  input  logic       issue_done_i,
  output slide_req_t commit_req_o,
  output logic       commit_valid_o,
  input  logic       commit_done_i
);

  localparam int unsigned Depth = `SLDU_INSN_DEPTH;
  localparam int unsigned PntW  = $clog2(Depth);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [PntW:0]   cnt_t;

  // Request storage
  slide_req_t [Depth-1:0] slot_q;
  slide_req_t             req_bytes;

  // One pointer per execution phase
  pnt_t accept_pnt_q;
  pnt_t issue_pnt_q;
  pnt_t commit_pnt_q;
  // Waiting to issue, and waiting to commit
  cnt_t issue_cnt_q;
  cnt_t commit_cnt_q;

  logic accept;

  // Pointer increment with wrap at the queue depth
  function automatic pnt_t pnt_next(pnt_t pnt);
    return (pnt == pnt_t'(Depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Full once every slot waits for commit
  assign req_ready_o = (commit_cnt_q != cnt_t'(Depth));
  assign accept      = req_valid_i && req_ready_o;

  assign issue_req_o    = slot_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign commit_req_o   = slot_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  // Stride scaled from elements to bytes on the way in
  always_comb begin
    req_bytes        = req_i;
    req_bytes.stride = req_i.stride << req_i.vsew;
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      slot_q[accept_pnt_q] <= req_bytes;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) begin
        accept_pnt_q <= pnt_next(accept_pnt_q);
      end
      if (issue_done_i) begin
        issue_pnt_q <= pnt_next(issue_pnt_q);
      end
      if (commit_done_i) begin
        commit_pnt_q <= pnt_next(commit_pnt_q);
      end
      // Accept and retire may land in the same cycle
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit_done_i);
    end
  end

  // Never more than Depth held, and issue never runs ahead of accept
  a_cnt_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (commit_cnt_q <= cnt_t'(Depth)) && (issue_cnt_q <= commit_cnt_q));

  // Engine and result queue only retire what this queue offered
  a_done_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (!issue_done_i || issue_valid_o) && (!commit_done_i || commit_valid_o));

endmodule

/* slide/slide_engine.sv */
// ------------------------------------------------
// Slide engine
// Moves source operand bytes into destination
// words at the slide offset, one word at a time
// ------------------------------------------------

`include "sldu_macros.svh"

module slide_engine import sldu_pkg::*; (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  slide_req_t                 issue_req_i,
  input  logic                       issue_valid_i,
  output logic                       issue_done_o,
  input  elen_t [`SLDU_NR_LANES-1:0] operand_i,
  input  logic  [`SLDU_NR_LANES-1:0] operand_valid_i,
  output logic                       operand_ready_o,
  result_word_if.master              word_o
);

  localparam int unsigned WordBytes = `SLDU_WORD_BYTES;
  localparam int unsigned PntW      = $clog2(WordBytes) + 1;

  // Byte position within one word, inclusive of the word size
  typedef logic [PntW-1:0] pnt_t;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e state_q, state_d;
  // Next byte to read and next byte to write
  pnt_t   in_pnt_q, in_pnt_d;
  pnt_t   out_pnt_q, out_pnt_d;
  // Bytes still to be copied for this instruction
  vlen_t  rem_q, rem_d;
  // Destination word index within the register
  vaddr_t widx_q, widx_d;

  // Destination word being built
  logic [WordBytes-1:0][7:0] buf_q, buf_d;
  logic [WordBytes-1:0]      be_q, be_d;
  // Operand seen as a flat byte array, lane 0 lowest
  logic [WordBytes-1:0][7:0] op_bytes;

  vlen_t vl_bytes;
  pnt_t  in_left;
  pnt_t  out_left;
  vlen_t take;
  vlen_t nbytes;
  logic  last;

  assign op_bytes = operand_i;
  assign vl_bytes = issue_req_i.vl << issue_req_i.vsew;

  // Copy up to the end of the shorter word
  assign in_left  = pnt_t'(WordBytes) - in_pnt_q;
  assign out_left = pnt_t'(WordBytes) - out_pnt_q;
  assign take     = (in_left < out_left) ? vlen_t'(in_left) : vlen_t'(out_left);
  assign last     = (rem_q <= take);
  assign nbytes   = last ? rem_q : take;

  always_comb begin
    state_d   = state_q;
    in_pnt_d  = in_pnt_q;
    out_pnt_d = out_pnt_q;
    rem_d     = rem_q;
    widx_d    = widx_q;
    buf_d     = buf_q;
    be_d      = be_q;

    operand_ready_o = 1'b0;
    issue_done_o    = 1'b0;
    word_o.push     = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (issue_valid_i) begin
          if (issue_req_i.op == SLIDE_UP) begin
            // Read from source start, write from first touched word
            in_pnt_d  = '0;
            out_pnt_d = pnt_t'(issue_req_i.stride % WordBytes);
            widx_d    = vaddr_t'(issue_req_i.stride / WordBytes);
            rem_d     = (vl_bytes > issue_req_i.stride) ? vl_bytes - issue_req_i.stride : '0;
          end else begin
            // Read from the offset, write from destination byte 0
            in_pnt_d  = pnt_t'(issue_req_i.stride % WordBytes);
            out_pnt_d = '0;
            widx_d    = '0;
            rem_d     = vl_bytes;
          end
          // Nothing to write, retire at once
          if (rem_d == '0) begin
            issue_done_o = 1'b1;
          end else begin
            state_d = RUN;
          end
        end
      end

      RUN: begin
        // Full operand present and room for a word
        if (&operand_valid_i && !word_o.full) begin
          for (int o = 0; o < WordBytes; o++) begin
            if (o >= out_pnt_q && o < out_pnt_q + nbytes) begin
              buf_d[o] = op_bytes[in_pnt_q + o - out_pnt_q];
              be_d[o]  = 1'b1;
            end
          end

          in_pnt_d  = in_pnt_q + pnt_t'(take);
          out_pnt_d = out_pnt_q + pnt_t'(take);
          rem_d     = last ? '0 : rem_q - take;

          // Input word used up, ask for the next one
          if (in_pnt_d == pnt_t'(WordBytes) || last) begin
            in_pnt_d        = '0;
            operand_ready_o = 1'b1;
          end

          // Destination word full or instruction over
          if (out_pnt_d == pnt_t'(WordBytes) || last) begin
            out_pnt_d   = '0;
            word_o.push = 1'b1;
            widx_d      = widx_q + 1'b1;
          end

          if (last) begin
            state_d      = IDLE;
            issue_done_o = 1'b1;
          end
        end
      end

      default: state_d = IDLE;
    endcase
  end

  // Word leaves with this cycle's bytes merged in
  assign word_o.data = buf_d;
  assign word_o.be   = be_d;
  assign word_o.addr = vaddr_t'(issue_req_i.vd * `SLDU_REG_WORDS) + widx_q;
  assign word_o.id   = issue_req_i.id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      in_pnt_q  <= '0;
      out_pnt_q <= '0;
      rem_q     <= '0;
      widx_q    <= '0;
      be_q      <= '0;
    end else begin
      state_q   <= state_d;
      in_pnt_q  <= in_pnt_d;
      out_pnt_q <= out_pnt_d;
      rem_q     <= rem_d;
      widx_q    <= widx_d;
      // Fresh word starts with all enables clear
      be_q      <= word_o.push ? '0 : be_d;
    end
  end

  always_ff @(posedge clk_i) begin
    buf_q <= buf_d;
  end

endmodule

/* hdl/result_queue.sv */
// ------------------------------------------------
// Result word queue
// Holds destination words until every lane grants
// and reports when an instruction is fully written
// ------------------------------------------------

`include "sldu_macros.svh"

module result_queue import sldu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  result_word_if.slave                word_i,
  input  slide_req_t                  commit_req_i,
  input  logic                        commit_valid_i,
  output logic                        commit_done_o,
  output done_vec_t                   done_o,
  output logic   [`SLDU_NR_LANES-1:0] result_req_o,
  output vaddr_t [`SLDU_NR_LANES-1:0] result_addr_o,
  output vid_t   [`SLDU_NR_LANES-1:0] result_id_o,
  output elen_t  [`SLDU_NR_LANES-1:0] result_wdata_o,
  output strb_t  [`SLDU_NR_LANES-1:0] result_be_o,
  input  logic   [`SLDU_NR_LANES-1:0] result_gnt_i
);

  localparam int unsigned Depth     = `SLDU_RESULT_DEPTH;
  localparam int unsigned Lanes     = `SLDU_NR_LANES;
  localparam int unsigned WordBytes = `SLDU_WORD_BYTES;
  localparam int unsigned PntW      = $clog2(Depth);

  typedef logic [PntW-1:0] pnt_t;
  typedef logic [PntW:0]   cnt_t;

  // Entry payload
  elen_t  [Depth-1:0][Lanes-1:0] data_q;
  strb_t  [Depth-1:0][Lanes-1:0] be_q;
  vaddr_t [Depth-1:0]            addr_q;
  vid_t   [Depth-1:0]            id_q;
  // Lanes still waiting for a grant, per entry
  logic   [Depth-1:0][Lanes-1:0] valid_q, valid_d;

  pnt_t wr_pnt_q;
  pnt_t rd_pnt_q;
  cnt_t cnt_q;
  logic retire;

  // Words left of the commit instruction
  vlen_t     vl_bytes;
  vlen_t     words;
  vlen_t     left_q, left_d;
  logic      loaded_q;
  done_vec_t done_d;

  function automatic pnt_t pnt_next(pnt_t pnt);
    return (pnt == pnt_t'(Depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign word_i.full = (cnt_q == cnt_t'(Depth));

  // Head entry drives every lane
  always_comb begin
    for (int l = 0; l < Lanes; l++) begin
      result_req_o[l]   = valid_q[rd_pnt_q][l];
      result_addr_o[l]  = addr_q[rd_pnt_q];
      result_id_o[l]    = id_q[rd_pnt_q];
      result_wdata_o[l] = data_q[rd_pnt_q][l];
      result_be_o[l]    = be_q[rd_pnt_q][l];
    end
  end

  // Grants clear lanes, head retires once all are clear
  always_comb begin
    valid_d           = valid_q;
    valid_d[rd_pnt_q] = valid_q[rd_pnt_q] & ~result_gnt_i;
    retire            = (cnt_q != '0) && (valid_d[rd_pnt_q] == '0);
    if (word_i.push) begin
      valid_d[wr_pnt_q] = '1;
    end
  end

  // Word count of the commit instruction, minus trimmed words
  assign vl_bytes = commit_req_i.vl << commit_req_i.vsew;

  always_comb begin
    words = vlen_t'((32'(vl_bytes) + WordBytes - 1) / WordBytes);
    if (commit_req_i.op == SLIDE_UP) begin
      if (vl_bytes <= commit_req_i.stride) begin
        words = '0;
      end else begin
        words = words - vlen_t'(commit_req_i.stride / WordBytes);
      end
    end
  end

  // Count taken from the request on first sight, then counted down
  always_comb begin
    left_d        = (loaded_q ? left_q : words) - vlen_t'(retire);
    commit_done_o = commit_valid_i && (left_d == '0);
    done_d        = '0;
    if (commit_done_o) begin
      done_d[commit_req_i.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (word_i.push) begin
      data_q[wr_pnt_q] <= word_i.data;
      be_q[wr_pnt_q]   <= word_i.be;
      addr_q[wr_pnt_q] <= word_i.addr;
      id_q[wr_pnt_q]   <= word_i.id;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
      left_q   <= '0;
      loaded_q <= 1'b0;
      done_o   <= '0;
    end else begin
      valid_q <= valid_d;
      if (word_i.push) begin
        wr_pnt_q <= pnt_next(wr_pnt_q);
      end
      if (retire) begin
        rd_pnt_q <= pnt_next(rd_pnt_q);
      end
      cnt_q <= cnt_q + cnt_t'(word_i.push) - cnt_t'(retire);
      if (commit_done_o) begin
        loaded_q <= 1'b0;
      end else if (commit_valid_i) begin
        loaded_q <= 1'b1;
        left_q   <= left_d;
      end
      // Registered one-cycle done pulse
      done_o <= done_d;
    end
  end

  // Engine holds off while the queue is full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_i.push |-> !word_i.full);

  // Lanes only grant a pending request
  a_gnt_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_gnt_i & ~result_req_o) == '0);

  // Every retired word belongs to an instruction awaiting commit
  a_retire_owned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    retire |-> commit_valid_i);

endmodule

/* hdl/sldu_top.sv */
// ------------------------------------------------
// Slide unit top level
// Instruction queue, slide engine and result queue
// ------------------------------------------------

`include "sldu_macros.svh"

module sldu_top import sldu_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Sequencer request
  input  vid_t                        req_id_i,
  input  slide_op_e                   req_op_i,
  input  vsew_e                       req_vsew_i,
  input  vreg_t                       req_vd_i,
  input  vlen_t                       req_vl_i,
  input  vlen_t                       req_stride_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  // Source operands from the lanes
  input  elen_t  [`SLDU_NR_LANES-1:0] operand_i,
  input  logic   [`SLDU_NR_LANES-1:0] operand_valid_i,
  output logic                        operand_ready_o,
  // Result writes to the lanes
  output logic   [`SLDU_NR_LANES-1:0] result_req_o,
  output vaddr_t [`SLDU_NR_LANES-1:0] result_addr_o,
  output vid_t   [`SLDU_NR_LANES-1:0] result_id_o,
  output elen_t  [`SLDU_NR_LANES-1:0] result_wdata_o,
  output strb_t  [`SLDU_NR_LANES-1:0] result_be_o,
  input  logic   [`SLDU_NR_LANES-1:0] result_gnt_i,
  output done_vec_t                   done_o
);

  slide_req_t req;
  slide_req_t issue_req;
  slide_req_t commit_req;
  logic       issue_valid;
  logic       issue_done;
  logic       commit_valid;
  logic       commit_done;

  // Request fields gathered into one struct
  assign req = '{
    id:     req_id_i,
    op:     req_op_i,
    vsew:   req_vsew_i,
    vd:     req_vd_i,
    vl:     req_vl_i,
    stride: req_stride_i
  };

  result_word_if word_if0 ();

  insn_queue insn_queue0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .issue_req_o    (issue_req),
    .issue_valid_o  (issue_valid),
    .issue_done_i   (issue_done),
    .commit_req_o   (commit_req),
    .commit_valid_o (commit_valid),
    .commit_done_i  (commit_done)
  );

  slide_engine slide_engine0 (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_req_i     (issue_req),
    .issue_valid_i   (issue_valid),
    .issue_done_o    (issue_done),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .word_o          (word_if0.master)
  );

  result_queue result_queue0 (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .word_i         (word_if0.slave),
    .commit_req_i   (commit_req),
    .commit_valid_i (commit_valid),
    .commit_done_o  (commit_done),
    .done_o         (done_o),
    .result_req_o   (result_req_o),
    .result_addr_o  (result_addr_o),
    .result_id_o    (result_id_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i)
  );

endmodule

/* testbench/tb_sldu.sv */
// ------------------------------------------------
// Slide unit testbench
// Table of slide instructions against a byte-level
// model, with operand supply and random lane grants
// ------------------------------------------------

`include "sldu_macros.svh"

module tb_sldu import sldu_pkg::*;;

  localparam int NL      = `SLDU_NR_LANES;
  localparam int WB      = `SLDU_WORD_BYTES;
  localparam int NR_ROWS = 9;
  localparam int MAX_W   = 64;
  localparam int TIMEOUT = 2000;

  typedef elen_t [NL-1:0] word_t;

  // One instruction and the number of words it should write
  typedef struct {
    slide_op_e op;
    vsew_e     sew;
    int        vd;
    int        vl;
    int        stride;
    int        id;
    int        words;
  } row_t;

  logic                 clk_i;
  logic                 rst_ni;
  vid_t                 req_id_i;
  slide_op_e            req_op_i;
  vsew_e                req_vsew_i;
  vreg_t                req_vd_i;
  vlen_t                req_vl_i;
  vlen_t                req_stride_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  word_t                operand_i;
  logic      [NL-1:0]   operand_valid_i;
  logic                 operand_ready_o;
  logic      [NL-1:0]   result_req_o;
  vaddr_t    [NL-1:0]   result_addr_o;
  vid_t      [NL-1:0]   result_id_o;
  word_t                result_wdata_o;
  strb_t     [NL-1:0]   result_be_o;
  logic      [NL-1:0]   result_gnt_i;
  done_vec_t            done_o;

  row_t   rows [NR_ROWS];
  // Expected destination words in write order
  int     exp_addr [MAX_W];
  int     exp_id [MAX_W];
  word_t  exp_data [MAX_W];
  strb_t  exp_be [MAX_W][NL];
  int     cum_words [NR_ROWS];
  int     n_exp;
  // Grants seen per lane, done pulses seen, operand position
  int     lane_cnt [NL];
  int     done_count;
  int     op_row;
  int     op_idx;
  logic   hold;
  integer seed;

  sldu_top dut0 (.*);

  always #20 clk_i = ~clk_i;

  task automatic flag_mismatch(input string msg);
    $display("[ERROR] %0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("Timed out at %0t while waiting for %s", $time, what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  function automatic int byte_count(int r);
    return rows[r].vl << int'(rows[r].sew);
  endfunction

  function automatic int offset_bytes(int r);
    return rows[r].stride << int'(rows[r].sew);
  endfunction

  // Slide-down reads from the offset onward, slide-up from byte 0
  function automatic int first_src_word(int r);
    return (rows[r].op == SLIDE_UP) ? 0 : offset_bytes(r) / WB;
  endfunction

  function automatic int src_word_count(int r);
    int s;
    int n;
    s = (rows[r].op == SLIDE_UP) ? 0 : offset_bytes(r);
    n = (rows[r].op == SLIDE_UP) ? byte_count(r) - offset_bytes(r) : byte_count(r);
    return (s + n - 1) / WB - s / WB + 1;
  endfunction

  // Source byte k holds k plus the id
  function automatic word_t operand_word(int r, int idx);
    word_t w;
    int    k;
    w = '0;
    if (r < NR_ROWS) begin
      for (int l = 0; l < NL; l++) begin
        for (int b = 0; b < 8; b++) begin
          k = (first_src_word(r) + idx) * WB + l * 8 + b;
          w[l][8*b +: 8] = 8'(k + rows[r].id);
        end
      end
    end
    return w;
  endfunction

  function automatic elen_t strb_mask(strb_t be);
    elen_t m;
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  task automatic load_table();
    // Slide-downs at every width, then slide-ups with trimmed words
    rows[0] = '{SLIDE_DOWN, EW8,  1, 40,  3,  0, 2};
    rows[1] = '{SLIDE_DOWN, EW16, 2, 20,  5,  1, 2};
    rows[2] = '{SLIDE_DOWN, EW32, 3, 16,  9,  2, 2};
    rows[3] = '{SLIDE_DOWN, EW64, 4, 5,   2,  3, 2};
    rows[4] = '{SLIDE_UP,   EW8,  5, 100, 70, 4, 2};
    rows[5] = '{SLIDE_UP,   EW32, 6, 24,  10, 5, 2};
    rows[6] = '{SLIDE_UP,   EW16, 7, 64,  16, 6, 3};
    rows[7] = '{SLIDE_DOWN, EW8,  0, 64,  0,  7, 2};
    // Run with grants held back
    rows[8] = '{SLIDE_DOWN, EW64, 8, 16,  1,  0, 4};
  endtask

  // Destination image per row, only words with an enabled byte
  task automatic build_model();
    int   vlb;
    int   off;
    int   j;
    int   k;
    int   start;
    logic en;
    logic any;
    n_exp = 0;
    for (int r = 0; r < NR_ROWS; r++) begin
      vlb   = byte_count(r);
      off   = offset_bytes(r);
      start = n_exp;
      for (int w = 0; w < `SLDU_REG_WORDS; w++) begin
        any = 1'b0;
        for (int l = 0; l < NL; l++) begin
          for (int b = 0; b < 8; b++) begin
            j = w * WB + l * 8 + b;
            if (rows[r].op == SLIDE_UP) begin
              en = (j >= off) && (j < vlb);
              k  = j - off;
            end else begin
              en = (j < vlb);
              k  = j + off;
            end
            exp_be[n_exp][l][b]          = en;
            exp_data[n_exp][l][8*b +: 8] = en ? 8'(k + rows[r].id) : 8'h00;
            any                          = any | en;
          end
        end
        if (any) begin
          exp_addr[n_exp] = rows[r].vd * `SLDU_REG_WORDS + w;
          exp_id[n_exp]   = rows[r].id;
          n_exp++;
        end
      end
      cum_words[r] = n_exp;
      assert (n_exp - start == rows[r].words) else
        flag_mismatch($sformatf("model gives %0d words for row %0d", n_exp - start, r));
    end
  endtask

  // Lane l takes its next expected word on every grant
  task automatic check_lane_write(input int l);
    int k;
    k = lane_cnt[l];
    assert (k < n_exp) else flag_mismatch($sformatf("extra write on lane %0d", l));
    assert (int'(result_addr_o[l]) == exp_addr[k] && int'(result_id_o[l]) == exp_id[k]) else
      flag_mismatch($sformatf("lane %0d word %0d addr %0d id %0d, expected addr %0d id %0d",
                              l, k, result_addr_o[l], result_id_o[l], exp_addr[k], exp_id[k]));
    assert (result_be_o[l] == exp_be[k][l]) else
      flag_mismatch($sformatf("lane %0d word %0d be %h, expected %h",
                              l, k, result_be_o[l], exp_be[k][l]));
    assert ((result_wdata_o[l] & strb_mask(exp_be[k][l])) == exp_data[k][l]) else
      flag_mismatch($sformatf("lane %0d word %0d data %h, expected %h",
                              l, k, result_wdata_o[l], exp_data[k][l]));
    lane_cnt[l]++;
  endtask

  // Pulses come in table order, after every word of the row
  task automatic check_done_pulse();
    assert (done_count < NR_ROWS) else flag_mismatch("done_o pulse with nothing in flight");
    assert (done_o == done_vec_t'(1) << rows[done_count].id) else
      flag_mismatch($sformatf("done_o %b for row %0d with id %0d",
                              done_o, done_count, rows[done_count].id));
    for (int l = 0; l < NL; l++) begin
      assert (lane_cnt[l] == cum_words[done_count]) else
        flag_mismatch($sformatf("done for row %0d with lane %0d at %0d of %0d words",
                                done_count, l, lane_cnt[l], cum_words[done_count]));
    end
    done_count++;
  endtask

  // Lane side: operands, random grants and write checks
  always @(negedge clk_i) begin : lane_side
    integer rnd;
    rnd = $random(seed);
    if (done_o != '0) begin
      check_done_pulse();
    end
    operand_i = operand_word(op_row, op_idx);
    // Lanes drop their operand valid now and then
    operand_valid_i = hold ? '1 : (rnd[NL +: NL] | {NL{rnd[2*NL]}});
    // Ready follows the valids combinationally
    #1;
    if (operand_ready_o) begin
      assert (op_row < NR_ROWS) else flag_mismatch("operand taken with no instruction left");
      op_idx++;
      if (op_idx == src_word_count(op_row)) begin
        op_row++;
        op_idx = 0;
      end
    end
    result_gnt_i = hold ? '0 : (result_req_o & rnd[NL-1:0]);
    for (int l = 0; l < NL; l++) begin
      if (result_gnt_i[l]) begin
        check_lane_write(l);
      end
    end
  end

  // Called on a falling edge, returns on one with valid dropped
  task automatic send_req(input int r, output int waited, output int done_seen);
    int t;
    t            = 0;
    waited       = 0;
    req_id_i     = vid_t'(rows[r].id);
    req_op_i     = rows[r].op;
    req_vsew_i   = rows[r].sew;
    req_vd_i     = vreg_t'(rows[r].vd);
    req_vl_i     = vlen_t'(rows[r].vl);
    req_stride_i = vlen_t'(rows[r].stride);
    req_valid_i  = 1'b1;
    #1;
    while (!req_ready_o) begin
      waited = 1;
      t++;
      if (t > TIMEOUT) abort_on_timeout("req_ready_o");
      @(negedge clk_i);
      #1;
    end
    done_seen = done_count;
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic wait_done(input int n);
    int t;
    t = 0;
    while (done_count < n) begin
      t++;
      if (t > TIMEOUT) abort_on_timeout("done_o pulses");
      @(posedge clk_i);
    end
  endtask

  initial begin : stimulus
    int    waited;
    int    done_seen;
    int    t;
    logic  lanes_ok;
    logic  [NL-1:0] held_req;
    word_t held_data;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    req_id_i        = '0;
    req_op_i        = SLIDE_UP;
    req_vsew_i      = EW8;
    req_vd_i        = '0;
    req_vl_i        = '0;
    req_stride_i    = '0;
    req_valid_i     = 1'b0;
    operand_i       = '0;
    operand_valid_i = '1;
    result_gnt_i    = '0;
    hold            = 1'b0;
    seed            = 32'h4137_e116;
    done_count      = 0;
    op_row          = 0;
    op_idx          = 0;
    for (int l = 0; l < NL; l++) begin
      lane_cnt[l] = 0;
    end
    load_table();
    build_model();

    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (req_ready_o && !operand_ready_o && result_req_o == '0 && done_o == '0) else
      flag_mismatch("outputs not idle after reset");

    // Back to back, third request waits for the first commit
    for (int r = 0; r < NR_ROWS - 1; r++) begin
      send_req(r, waited, done_seen);
      if (r < 2) begin
        assert (done_seen == 0) else flag_mismatch($sformatf("row %0d accepted late", r));
      end
      if (r == 2) begin
        assert (waited == 1 && done_seen >= 1) else
          flag_mismatch("third request accepted before a commit");
      end
    end
    wait_done(NR_ROWS - 1);

    // Grants held, queue fills and the engine stalls
    @(posedge clk_i);
    hold = 1'b1;
    @(negedge clk_i);
    send_req(NR_ROWS - 1, waited, done_seen);
    t = 0;
    while (result_req_o == '0) begin
      t++;
      if (t > TIMEOUT) abort_on_timeout("result_req_o");
      @(negedge clk_i);
    end
    held_req  = result_req_o;
    held_data = result_wdata_o;
    for (int i = 0; i < 16; i++) begin
      @(negedge clk_i);
      assert (result_req_o == held_req && result_wdata_o == held_data) else
        flag_mismatch("result word changed while grants held");
      if (i >= 8) begin
        assert (!operand_ready_o) else flag_mismatch("operand_ready_o high with queue full");
      end
    end
    assert (done_count == NR_ROWS - 1) else flag_mismatch("done_o while grants held");
    @(posedge clk_i);
    hold = 1'b0;
    wait_done(NR_ROWS);
    repeat (4) @(negedge clk_i);

    lanes_ok = 1'b1;
    for (int l = 0; l < NL; l++) begin
      lanes_ok = lanes_ok && (lane_cnt[l] == n_exp);
    end
    if (lanes_ok && done_count == NR_ROWS && result_req_o == '0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "run ended with words or done pulses missing");
    end
  end

endmodule

/* list.f */
+incdir+common
common/sldu_pkg.sv
common/result_word_if.sv
hdl/insn_queue.sv
slide/slide_engine.sv
hdl/result_queue.sv
hdl/sldu_top.sv
testbench/tb_sldu.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the slide unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_sldu -Mdir obj_dir -f list.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_sldu > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
